/* bram_pkg.sv */
//--------------------------------------
// shared bus fields, register map, memory
// depths and payload types
//--------------------------------------
package bram_pkg;

  // host bus
  localparam int BUS_ADDR_W = 17;
  localparam int BUS_DATA_W = 16;
  localparam int WORD_ADDR_W = 14;

  typedef logic [1:0] sel_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [BUS_DATA_W-1:0] bus_word_t;

  // target select, code 3 is unused
  localparam sel_t SEL_CTL = 2'd0;
  localparam sel_t SEL_MOD = 2'd1;
  localparam sel_t SEL_DRIVE = 2'd2;

  // controller register map
  localparam word_addr_t ADDR_CTL_FLAG = 14'd0;
  localparam word_addr_t ADDR_MOD_CYCLE = 14'd1;
  localparam word_addr_t ADDR_MOD_FREQ_DIV_0 = 14'd2;
  localparam word_addr_t ADDR_MOD_FREQ_DIV_1 = 14'd3;

  localparam int CTL_RUN_BIT = 0;

  // 256 words hold 512 modulation bytes
  localparam int MOD_DEPTH = 256;
  localparam int NUM_TRANS = 64;

  typedef logic [5:0] trans_idx_t;

  // lo byte is the even sample
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } mod_word_t;

  typedef struct packed {
    logic [7:0] duty;
    logic [7:0] phase;
  } drive_t;

endpackage

/* bram_wr_if.sv */
//--------------------------------------
// one decoded host write, decoder to storage
//--------------------------------------
interface bram_wr_if import bram_pkg::*;;

  logic wr;
  sel_t sel;
  word_addr_t addr;
  bus_word_t data;

  // sel, addr and data only meaningful while wr is high
  modport src(output wr, output sel, output addr, output data);
  modport dst(input wr, input sel, input addr, input data);

endinterface

/* cpu_bus_decoder.sv */
//--------------------------------------
// host bus decoder, one write pulse per
// write-enable assertion
//--------------------------------------
module cpu_bus_decoder import bram_pkg::*; (
  input logic CPU_CKIO,
  input logic reset,
  input logic cs_n,
  input logic we_n,
  input logic [BUS_ADDR_W-1:0] addr,
  input bus_word_t data,
  bram_wr_if.src wr_bus
);

  logic we_n_q;
  logic fire;

  // first edge with we_n low after it was high, under chip select
  assign fire = ~cs_n & ~we_n & we_n_q;

  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      we_n_q <= 1'b1;
      wr_bus.wr <= 1'b0;
    end else begin
      we_n_q <= we_n;
      wr_bus.wr <= fire;
    end
  end

  // bit 0 is the byte lane, the word address starts at bit 1
  always_ff @(posedge CPU_CKIO) begin
    if (fire) begin
      wr_bus.sel <= addr[16:15];
      wr_bus.addr <= addr[14:1];
      wr_bus.data <= data;
    end
  end

endmodule

/* controller_regs.sv */
//--------------------------------------
// controller registers: run flag, mod cycle
// and mod frequency divider
//--------------------------------------
module controller_regs import bram_pkg::*; (
  input logic CPU_CKIO,
  input logic reset,
  bram_wr_if.dst wr_bus,
  output logic run,
  output logic [15:0] mod_cycle,
  output logic [31:0] mod_freq_div
);

  logic ctl_wr;

  assign ctl_wr = wr_bus.wr && (wr_bus.sel == SEL_CTL);

  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      run <= 1'b0;
      mod_cycle <= '0;
      mod_freq_div <= '0;
    end else if (ctl_wr) begin
      case (wr_bus.addr)
        ADDR_CTL_FLAG: begin
          run <= wr_bus.data[CTL_RUN_BIT];
        end
        ADDR_MOD_CYCLE: begin
          mod_cycle <= wr_bus.data;
        end
        // divider is written as two half words
        ADDR_MOD_FREQ_DIV_0: begin
          mod_freq_div[15:0] <= wr_bus.data;
        end
        ADDR_MOD_FREQ_DIV_1: begin
          mod_freq_div[31:16] <= wr_bus.data;
        end
        default: begin
          // unknown address, ignored
        end
      endcase
    end
  end

endmodule

/* bram_dp.sv */
//--------------------------------------
// simple dual port ram, registered read
//--------------------------------------
module bram_dp import bram_pkg::*; #(
  parameter type word_t = bus_word_t,
  parameter int DEPTH = MOD_DEPTH
) (
  input logic CPU_CKIO,
  input logic we,
  input word_addr_t waddr,
  input word_t wdata,
  input word_addr_t raddr,
  output word_t rdata
);

  localparam int AW = $clog2(DEPTH);

  word_t mem[DEPTH];

  // writes past the depth are dropped rather than aliased
  always_ff @(posedge CPU_CKIO) begin
    if (we && (waddr < word_addr_t'(DEPTH))) begin
      mem[waddr[AW-1:0]] <= wdata;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rdata <= mem[raddr[AW-1:0]];
  end

endmodule

/* mod_sampler.sv */
//--------------------------------------
// modulation sampler, one byte per divider
// period
//--------------------------------------
module mod_sampler import bram_pkg::*; (
  input logic CPU_CKIO,
  input logic reset,
  input logic run,
  input logic [15:0] mod_cycle,
  input logic [31:0] mod_freq_div,
  output word_addr_t raddr,
  input mod_word_t rdata,
  output logic mod_update,
  output logic [7:0] mod_value
);

  logic [31:0] div_cnt;
  logic [15:0] idx;
  logic step;
  logic step_q;
  logic odd_q;

  // a step happens at the start of every divider period
  assign step = run && (div_cnt == '0);
  assign raddr = idx[14:1];

  always_ff @(posedge CPU_CKIO) begin
    if (reset || !run) begin
      div_cnt <= '0;
      idx <= '0;
    end else begin
      div_cnt <= (div_cnt >= mod_freq_div) ? '0 : div_cnt + 32'd1;
      if (step) begin
        idx <= (idx >= mod_cycle) ? '0 : idx + 16'd1;
      end
    end
  end

  // word is read at the step, byte picked one cycle later
  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      step_q <= 1'b0;
      odd_q <= 1'b0;
      mod_update <= 1'b0;
      mod_value <= '0;
    end else begin
      step_q <= step;
      odd_q <= idx[0];
      mod_update <= step_q;
      if (step_q) begin
        mod_value <= odd_q ? rdata.hi : rdata.lo;
      end
    end
  end

endmodule

/* drive_scanner.sv */
//--------------------------------------
// drive scanner, streams modulated duty and
// phase for every transducer
//--------------------------------------
module drive_scanner import bram_pkg::*; (
  input logic CPU_CKIO,
  input logic reset,
  input logic run,
  input logic [7:0] mod_value,
  output word_addr_t raddr,
  input drive_t rdata,
  output logic drive_valid,
  output trans_idx_t drive_idx,
  output logic [7:0] drive_duty,
  output logic [7:0] drive_phase
);

  trans_idx_t idx;
  trans_idx_t idx_q;
  logic valid_q;
  logic [15:0] scaled;

  assign raddr = word_addr_t'(idx);
  assign scaled = 16'(rdata.duty) * 16'(mod_value);

  always_ff @(posedge CPU_CKIO) begin
    if (reset || !run) begin
      idx <= '0;
    end else begin
      idx <= (idx == trans_idx_t'(NUM_TRANS - 1)) ? '0 : idx + 6'd1;
    end
  end

  // stage 1 runs alongside the ram read
  always_ff @(posedge CPU_CKIO) begin
    if (reset) begin
      valid_q <= 1'b0;
      drive_valid <= 1'b0;
    end else begin
      valid_q <= run;
      drive_valid <= valid_q;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    idx_q <= idx;
  end

  // stage 2, duty * mod / 256
  always_ff @(posedge CPU_CKIO) begin
    if (valid_q) begin
      drive_idx <= idx_q;
      drive_duty <= scaled[15:8];
      drive_phase <= rdata.phase;
    end
  end

endmodule

/* bram_bus_top.sv */
//--------------------------------------
// host write path, memories and output stage
//--------------------------------------
module bram_bus_top import bram_pkg::*; (
  input logic CPU_CKIO,
  input logic reset,
  input logic cs_n,
  input logic we_n,
  input logic [BUS_ADDR_W-1:0] addr,
  input bus_word_t data,
  output logic mod_update,
  output logic [7:0] mod_value,
  output logic drive_valid,
  output trans_idx_t drive_idx,
  output logic [7:0] drive_duty,
  output logic [7:0] drive_phase
);

  bram_wr_if wr_bus ();

  logic run;
  logic [15:0] mod_cycle;
  logic [31:0] mod_freq_div;
  logic mod_we;
  logic drive_we;
  word_addr_t mod_raddr;
  word_addr_t drive_raddr;
  mod_word_t mod_rdata;
  drive_t drive_rdata;

  assign mod_we = wr_bus.wr && (wr_bus.sel == SEL_MOD);
  assign drive_we = wr_bus.wr && (wr_bus.sel == SEL_DRIVE);

  cpu_bus_decoder u_cpu_bus_decoder (
    .CPU_CKIO(CPU_CKIO), .reset(reset), .cs_n(cs_n), .we_n(we_n),
    .addr(addr), .data(data), .wr_bus(wr_bus.src)
  );

  controller_regs u_controller_regs (
    .CPU_CKIO(CPU_CKIO), .reset(reset), .wr_bus(wr_bus.dst),
    .run(run), .mod_cycle(mod_cycle), .mod_freq_div(mod_freq_div)
  );

  bram_dp #(.word_t(mod_word_t), .DEPTH(MOD_DEPTH)) u_mod_ram (
    .CPU_CKIO(CPU_CKIO), .we(mod_we), .waddr(wr_bus.addr),
    .wdata(mod_word_t'(wr_bus.data)), .raddr(mod_raddr), .rdata(mod_rdata)
  );

  bram_dp #(.word_t(drive_t), .DEPTH(NUM_TRANS)) u_drive_ram (
    .CPU_CKIO(CPU_CKIO), .we(drive_we), .waddr(wr_bus.addr),
    .wdata(drive_t'(wr_bus.data)), .raddr(drive_raddr), .rdata(drive_rdata)
  );

  mod_sampler u_mod_sampler (
    .CPU_CKIO(CPU_CKIO), .reset(reset), .run(run), .mod_cycle(mod_cycle),
    .mod_freq_div(mod_freq_div), .raddr(mod_raddr), .rdata(mod_rdata),
    .mod_update(mod_update), .mod_value(mod_value)
  );

  drive_scanner u_drive_scanner (
    .CPU_CKIO(CPU_CKIO), .reset(reset), .run(run), .mod_value(mod_value),
    .raddr(drive_raddr), .rdata(drive_rdata), .drive_valid(drive_valid),
    .drive_idx(drive_idx), .drive_duty(drive_duty), .drive_phase(drive_phase)
  );

endmodule

/* bram_bus_checker.sv */
//--------------------------------------
// bus and output stream assertions
//--------------------------------------
module bram_bus_checker import bram_pkg::*; (
  input logic CPU_CKIO,
  input logic reset,
  input logic wr,
  input logic mod_update,
  input logic drive_valid,
  input trans_idx_t drive_idx
);

  // one strobe per write-enable assertion
  a_wr_single: assert property (@(posedge CPU_CKIO) disable iff (reset) wr |=> !wr)
    else $error("write strobe high for two cycles in a row");

  // outputs stay quiet while reset is held
  a_quiet_reset: assert property (@(posedge CPU_CKIO)
    (reset && $past(reset)) |-> (!drive_valid && !mod_update))
    else $error("output strobe active during reset");

  a_idx_range: assert property (@(posedge CPU_CKIO) disable iff (reset)
    drive_valid |-> (!$isunknown(drive_idx) && (32'(drive_idx) < NUM_TRANS)))
    else $error("drive index unknown or out of range");

endmodule

bind bram_bus_top bram_bus_checker u_bram_bus_checker (
  .CPU_CKIO(CPU_CKIO), .reset(reset), .wr(wr_bus.wr), .mod_update(mod_update),
  .drive_valid(drive_valid), .drive_idx(drive_idx)
);

/* bram_bus_top_tb.sv */
//--------------------------------------
// testbench for the host write path and
// the modulation and drive output stage
//--------------------------------------
module bram_bus_top_tb import bram_pkg::*; ();

  localparam int MAX_WRITES = 2 * NUM_TRANS + MOD_DEPTH + 16;
  localparam int WRITE_LEN = 8;
  localparam int MAX_SAMPLES = 511 + 16;
  localparam int MAX_DIV = 8;
  localparam int RUN_CYCLES = MAX_WRITES * WRITE_LEN + 3 * NUM_TRANS
                              + MAX_SAMPLES * MAX_DIV + 200;

  logic CPU_CKIO;
  logic reset;
  logic cs_n;
  logic we_n;
  logic [BUS_ADDR_W-1:0] addr;
  bus_word_t data;
  logic mod_update;
  logic [7:0] mod_value;
  logic drive_valid;
  trans_idx_t drive_idx;
  logic [7:0] drive_duty;
  logic [7:0] drive_phase;

  // reference model state
  logic [7:0] mod_bytes[2*MOD_DEPTH];
  logic [7:0] duty_m[NUM_TRANS];
  logic [7:0] phase_m[NUM_TRANS];

  // observed output stream, recorded at the falling edge
  longint cycle_cnt = 0;
  logic [7:0] mod_val_q[$];
  longint mod_cyc_q[$];
  logic [21:0] drive_q[$];

  // decoded write strobes seen inside the DUT
  int wr_cnt = 0;

  bram_bus_top u_bram_bus_top (
    .CPU_CKIO(CPU_CKIO), .reset(reset), .cs_n(cs_n), .we_n(we_n), .addr(addr),
    .data(data), .mod_update(mod_update), .mod_value(mod_value),
    .drive_valid(drive_valid), .drive_idx(drive_idx), .drive_duty(drive_duty),
    .drive_phase(drive_phase)
  );

  always #5 CPU_CKIO = ~CPU_CKIO;

  always @(negedge CPU_CKIO) begin
    cycle_cnt++;
    if (!reset && mod_update) begin
      mod_val_q.push_back(mod_value);
      mod_cyc_q.push_back(cycle_cnt);
    end
    if (!reset && drive_valid) begin
      drive_q.push_back({drive_idx, drive_duty, drive_phase});
    end
    if (!reset && u_bram_bus_top.wr_bus.wr) begin
      wr_cnt++;
    end
  end

  task automatic check_equal(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // setup on one edge, then we_n low for we_cycles edges
  task automatic host_write(input sel_t sel, input word_addr_t waddr,
                            input bus_word_t wdata, input int we_cycles);
    @(posedge CPU_CKIO);
    addr <= {sel, waddr, 1'b0};
    data <= wdata;
    cs_n <= 1'b0;
    @(posedge CPU_CKIO);
    we_n <= 1'b0;
    repeat (we_cycles) @(posedge CPU_CKIO);
    we_n <= 1'b1;
    @(posedge CPU_CKIO);
    cs_n <= 1'b1;
  endtask

  task automatic set_run(input logic on);
    host_write(SEL_CTL, ADDR_CTL_FLAG, bus_word_t'(on), 2);
    repeat (4) @(posedge CPU_CKIO);
  endtask

  task automatic set_modulation(input int unsigned cyc, input int unsigned div);
    host_write(SEL_CTL, ADDR_MOD_CYCLE, bus_word_t'(cyc), 2);
    host_write(SEL_CTL, ADDR_MOD_FREQ_DIV_0, bus_word_t'(div), 2);
    host_write(SEL_CTL, ADDR_MOD_FREQ_DIV_1, bus_word_t'(div >> 16), 2);
  endtask

  task automatic load_drive(input int we_cycles);
    bus_word_t w;
    for (int t = 0; t < NUM_TRANS; t++) begin
      w = bus_word_t'($urandom);
      duty_m[t] = w[15:8];
      phase_m[t] = w[7:0];
      host_write(SEL_DRIVE, word_addr_t'(t), w, we_cycles);
    end
  endtask

  // expects mod_value fixed at 255 for the whole scan
  task automatic check_scans(input int scans);
    logic [21:0] item;
    int exp_duty;
    drive_q.delete();
    set_run(1'b1);
    while (drive_q.size() < scans * NUM_TRANS) @(negedge CPU_CKIO);
    set_run(1'b0);
    for (int k = 0; k < scans * NUM_TRANS; k++) begin
      item = drive_q[k];
      exp_duty = (32'(duty_m[k % NUM_TRANS]) * 255) >> 8;
      check_equal("drive_idx", k % NUM_TRANS, 32'(item[21:16]));
      check_equal("drive_duty", exp_duty, 32'(item[15:8]));
      check_equal("drive_phase", 32'(phase_m[k % NUM_TRANS]), 32'(item[7:0]));
    end
  endtask

  initial begin
    repeat (2 * RUN_CYCLES) @(posedge CPU_CKIO);
    $display("Finished with errors");
    $fatal(1, "watchdog expired before the tests completed");
  end

  initial begin
    int unsigned cyc;
    int unsigned div;
    int n;
    bus_word_t w;
    void'($urandom(64));
    CPU_CKIO = 1'b0;
    reset = 1'b1;
    cs_n = 1'b1;
    we_n = 1'b1;
    addr = '0;
    data = '0;
    repeat (5) @(posedge CPU_CKIO);
    reset <= 1'b0;

    // idle after reset, run flag clear
    repeat (100) begin
      @(negedge CPU_CKIO);
      check_equal("drive_valid", 0, 32'(drive_valid));
      check_equal("mod_update", 0, 32'(mod_update));
    end

    // full-scale modulation, then two scans of random duty/phase
    w = {8'($urandom), 8'd255};
    mod_bytes[0] = 8'd255;
    host_write(SEL_MOD, '0, w, 2);
    set_modulation(0, 0);
    mod_val_q.delete();
    set_run(1'b1);
    while (mod_val_q.size() == 0) @(negedge CPU_CKIO);
    set_run(1'b0);
    check_equal("mod_value", 255, 32'(mod_value));
    load_drive(2);
    check_scans(2);

    // rewrite with a long write enable, one write each
    wr_cnt = 0;
    load_drive(4);
    check_equal("wr_bus.wr", NUM_TRANS, wr_cnt);
    check_scans(1);

    // random table, cycle length and divider
    for (int i = 0; i < MOD_DEPTH; i++) begin
      w = bus_word_t'($urandom);
      mod_bytes[2*i] = w[7:0];
      mod_bytes[2*i+1] = w[15:8];
      host_write(SEL_MOD, word_addr_t'(i), w, 2);
    end
    cyc = $urandom % 511;
    div = $urandom % MAX_DIV;
    set_modulation(cyc, div);
    n = int'(cyc) + 17;
    mod_val_q.delete();
    mod_cyc_q.delete();
    set_run(1'b1);
    while (mod_val_q.size() < n) @(negedge CPU_CKIO);
    set_run(1'b0);
    for (int k = 0; k < n; k++) begin
      check_equal("mod_value", 32'(mod_bytes[k % (int'(cyc) + 1)]), 32'(mod_val_q[k]));
      if (k > 0) begin
        check_equal("mod_update", int'(div) + 1, 32'(mod_cyc_q[k] - mod_cyc_q[k-1]));
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* bram_bus_top.f */
bram_pkg.sv
bram_wr_if.sv
cpu_bus_decoder.sv
controller_regs.sv
bram_dp.sv
mod_sampler.sv
drive_scanner.sv
bram_bus_top.sv
bram_bus_checker.sv
bram_bus_top_tb.sv

/* Makefile */
TOP := bram_bus_top_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f bram_bus_top.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f bram_bus_top.f

clean:
	rm -rf obj_dir
